/* dv/sharedMemTb.sv */
//=====================================================================
// Testbench for the dual-port APB scratchpad. Random transfers on both
// ports are checked against a reference memory by assertions.
//=====================================================================
`timescale 1ns/100ps

module sharedMemTb;

   logic                           clk = 1'b0;
   logic                           arstN;
   sharedMemPkg::apbReqT           apbA;
   sharedMemPkg::apbReqT           apbB;
   sharedMemPkg::apbRspT           rspA;
   sharedMemPkg::apbRspT           rspB;
   logic [31:0]                    lfsrState = 32'h4f33;
   logic [sharedMemPkg::DataW-1:0] refMem [2**sharedMemPkg::AddrW];  // Expected contents

   sharedMemTop sharedMemTop_i (
      .clk   (clk),
      .arstN (arstN),
      .apbA  (apbA),
      .apbB  (apbB),
      .rspA  (rspA),
      .rspB  (rspB)
   );

   always #2 clk = ~clk;  // 4 ns period

   // Bound APB checkers on both ports
   always @(negedge clk) begin
      if (sharedMemTop_i.portA.apbChecks.failCount != 0 ||
          sharedMemTop_i.portB.apbChecks.failCount != 0) begin
         $display("APB protocol assertion failed at %0t", $time);
         $display("Regression failed");
         $fatal(1, "Protocol check failure");
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] randBits(input int count);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < count; i++) begin
         fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         value     = {value[30:0], fb};
      end
      return value;
   endfunction

   function automatic logic [15:0] byteAddr(input logic [9:0] word);
      logic [15:0] addr;
      addr = '0;
      addr[sharedMemPkg::AddrW+1:2] = word;
      return addr;
   endfunction

   // Strobed bytes of the new word over the old one
   function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                              input logic [31:0] newWord,
                                              input logic [3:0]  strb);
      logic [31:0] result;
      result = oldWord;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            result[b*8 +: 8] = newWord[b*8 +: 8];
         end
      end
      return result;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic setBus(input bit portB, input sharedMemPkg::apbReqT value);
      if (portB) begin
         apbB <= value;
      end else begin
         apbA <= value;
      end
   endtask

   // One APB transfer, setup then access until pready
   task automatic apbTransfer(input bit portB, input bit write, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
      sharedMemPkg::apbReqT req;
      sharedMemPkg::apbRspT resp;
      int                   waited;
      bit                   done;
      req        = '0;
      req.psel   = 1'b1;
      req.pwrite = write;
      req.paddr  = addr;
      req.pwdata = wdata;
      req.pstrb  = write ? strb : 4'h0;
      @(posedge clk);
      setBus(portB, req);
      @(posedge clk);
      req.penable = 1'b1;
      setBus(portB, req);
      waited = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);  // Sample away from the driving edge
         resp = portB ? rspB : rspA;
         if (resp.pready) begin
            done = 1'b1;
         end else begin
            waited++;
            if (waited >= 50) begin
               $display("Port %s gave no pready within 50 cycles at %0t",
                        portB ? "B" : "A", $time);
               $display("Regression failed");
               $fatal(1, "APB transfer timed out");
            end else begin
               @(posedge clk);
            end
         end
      end
      rdata = resp.prdata;
      err   = resp.pslverr;
      @(posedge clk);
      setBus(portB, '0);
   endtask

   task automatic writeWord(input bit portB, input logic [9:0] word,
                            input logic [31:0] data, input logic [3:0] strb);
      logic [31:0] rdata;
      logic        err;
      apbTransfer(portB, 1'b1, byteAddr(word), data, strb, rdata, err);
      checkValue(portB ? "rspB.pslverr" : "rspA.pslverr", 32'd0, err);
      refMem[word] = mergeBytes(refMem[word], data, strb);
   endtask

   task automatic readCheck(input bit portB, input logic [9:0] word);
      logic [31:0] rdata;
      logic        err;
      apbTransfer(portB, 1'b0, byteAddr(word), 32'h0, 4'h0, rdata, err);
      checkValue(portB ? "rspB.pslverr" : "rspA.pslverr", 32'd0, err);
      checkValue(portB ? "rspB.prdata" : "rspA.prdata", refMem[word], rdata);
   endtask

   initial begin : stimulus
      logic [9:0]  addr;
      logic [15:0] badAddr;
      logic [31:0] dataA;
      logic [31:0] dataB;
      logic [31:0] rdA;
      logic [31:0] rdB;
      logic        errA;
      logic        errB;
      logic [3:0]  strb;
      time         doneA;
      time         doneB;
      apbA  = '0;
      apbB  = '0;
      arstN = 1'b0;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;

      // Quiet ports after reset
      repeat (3) begin
         @(negedge clk);
         checkValue("rspA.pready", 32'd0, rspA.pready);
         checkValue("rspB.pready", 32'd0, rspB.pready);
         checkValue("rspA.pslverr", 32'd0, rspA.pslverr);
         checkValue("rspB.pslverr", 32'd0, rspB.pslverr);
      end

      for (int i = 0; i < 30; i++) begin
         addr = randBits(10);
         writeWord(1'b0, addr, randBits(32), 4'hF);
         readCheck(1'b0, addr);
      end

      // Both ports see one memory
      for (int i = 0; i < 4; i++) begin
         addr = randBits(10);
         writeWord(1'b1, addr, randBits(32), 4'hF);
         readCheck(1'b0, addr);
         addr = randBits(10);
         writeWord(1'b0, addr, randBits(32), 4'hF);
         readCheck(1'b1, addr);
      end

      for (int i = 0; i < 8; i++) begin
         addr = randBits(10);
         writeWord(1'b0, addr, randBits(32), 4'hF);
         strb = randBits(4);
         if (strb == 4'h0 || strb == 4'hF) begin
            strb = strb ^ 4'b0110;  // Force a partial strobe
         end
         writeWord(i[0], addr, randBits(32), strb);
         readCheck(1'b0, addr);
      end

      // Same word written by both ports in one setup cycle
      for (int i = 0; i < 3; i++) begin
         addr  = randBits(10);
         dataA = randBits(32);
         dataB = randBits(32);
         fork
            begin
               apbTransfer(1'b0, 1'b1, byteAddr(addr), dataA, 4'hF, rdA, errA);
               doneA = $time;
            end
            begin
               apbTransfer(1'b1, 1'b1, byteAddr(addr), dataB, 4'hF, rdB, errB);
               doneB = $time;
            end
         join
         checkValue("rspA.pslverr", 32'd0, errA);
         checkValue("rspB.pslverr", 32'd0, errB);
         // B held once, so it ends one clock after A
         assert (doneB - doneA == 4) else begin
            $display("Port B was not held for one cycle on a same-word write at %0t", $time);
            $display("Regression failed");
            $fatal(1, "Write collision not held");
         end
         refMem[addr] = dataB;  // B lands after A
         readCheck(1'b0, addr);
      end

      // Out of range, aliased word must survive
      addr = randBits(10);
      writeWord(1'b0, addr, randBits(32), 4'hF);
      badAddr = byteAddr(addr);
      badAddr[sharedMemPkg::PAddrW-1] = 1'b1;
      apbTransfer(1'b0, 1'b1, badAddr, ~refMem[addr], 4'hF, rdA, errA);
      checkValue("rspA.pslverr", 32'd1, errA);
      checkValue("rspA.prdata", 32'd0, rdA);
      badAddr[sharedMemPkg::AddrW+2] = 1'b1;
      apbTransfer(1'b1, 1'b0, badAddr, 32'h0, 4'h0, rdB, errB);
      checkValue("rspB.pslverr", 32'd1, errB);
      checkValue("rspB.prdata", 32'd0, rdB);
      readCheck(1'b0, addr);
      readCheck(1'b1, addr);

      repeat (2) @(posedge clk);
      if (sharedMemTop_i.portA.apbChecks.failCount == 0 &&
          sharedMemTop_i.portB.apbChecks.failCount == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("APB protocol assertions reported failures");
         $display("Regression failed");
         $fatal(1, "Protocol check failures");
      end
   end

endmodule

/* dv/sharedMemTb_sva.sv */
//=====================================================================
// APB protocol checks, bound into every apbMemPort instance.
//=====================================================================
`timescale 1ns/100ps

module apbPortChecks (
   input logic                 clk,
   input logic                 arstN,
   input sharedMemPkg::apbReqT apb,
   input sharedMemPkg::apbRspT rsp
);

   int unsigned failCount = 0;  // Read by the testbench at the end

   // Master keeps the transfer steady through wait states
   stableWhileWaiting: assert property (@(posedge clk) disable iff (!arstN)
      (apb.psel && apb.penable && !rsp.pready) |=> $stable(apb))
      else begin
         $error("APB request changed while pready was low");
         failCount++;
      end

   readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
      rsp.pready |-> (apb.psel && apb.penable))
      else begin
         $error("pready high outside an access cycle");
         failCount++;
      end

   // Error only qualifies a completing transfer
   errWithReady: assert property (@(posedge clk) disable iff (!arstN)
      rsp.pslverr |-> rsp.pready)
      else begin
         $error("pslverr high without pready");
         failCount++;
      end

endmodule

bind apbMemPort apbPortChecks apbChecks (
   .clk   (clk),
   .arstN (arstN),
   .apb   (apb),
   .rsp   (rsp)
);

/* src/apbMemPort.sv */
//=====================================================================
// APB slave stage in front of one RAM port. Decodes transfers into
// RAM requests, retries held requests and builds the APB response.
//=====================================================================
`timescale 1ns/100ps

module apbMemPort (
   input  logic                           clk,
   input  logic                           arstN,
   input  sharedMemPkg::apbReqT           apb,
   output sharedMemPkg::apbRspT           rsp,
   input  logic                           hold,
   output sharedMemPkg::memReqT           req,
   input  logic [sharedMemPkg::DataW-1:0] rdata
);

   logic [sharedMemPkg::AddrW-1:0] wordAddr;
   logic                           inRange;
   logic                           setupPhase;
   logic                           accessDone;
   logic                           reqValid;
   logic                           issueNow;
   logic                           badStart;
   logic                           holdStart;
   logic                           pending;    // Held request waiting for a slot
   logic                           readyQ;
   logic                           errQ;

   // Range check
   assign wordAddr = apb.paddr[sharedMemPkg::AddrW+1:2];
   assign inRange  = ~|apb.paddr[sharedMemPkg::PAddrW-1:sharedMemPkg::AddrW+2];

   assign setupPhase = apb.psel & ~apb.penable;
   assign accessDone = apb.psel & apb.penable & readyQ;

   // Candidate request, before the guard decides on it
   assign reqValid  = (setupPhase & inRange) | pending;
   assign issueNow  = reqValid & ~hold;
   assign holdStart = setupPhase & inRange & hold;
   assign badStart  = setupPhase & ~inRange;

   always_comb begin
      req.en    = reqValid;  // Guard masks this when hold is raised
      req.be    = apb.pwrite ? apb.pstrb : '0;
      req.addr  = wordAddr;
      req.wdata = apb.pwdata;
   end

   // Issue control and response flags
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pending <= 1'b0;
         readyQ  <= 1'b0;
         errQ    <= 1'b0;
      end else begin
         pending <= holdStart | (pending & hold);
         if (accessDone) begin
            readyQ <= 1'b0;
            errQ   <= 1'b0;
         end else if (issueNow) begin
            readyQ <= 1'b1;  // RAM word valid next cycle
         end else if (badStart) begin
            readyQ <= 1'b1;
            errQ   <= 1'b1;
         end
      end
   end

   // RAM output is already registered, pass it while pready is up
   always_comb begin
      rsp.pready  = readyQ;
      rsp.pslverr = errQ;
      if (readyQ && !errQ && !apb.pwrite) begin
         rsp.prdata = rdata;
      end else begin
         rsp.prdata = '0;
      end
   end

endmodule

/* src/dpRamBe.sv */
//=====================================================================
// True dual-port block RAM, read-first, with per-byte write enables.
// Each port takes a memReqT and returns the old word one cycle later.
//=====================================================================
`timescale 1ns/100ps

module dpRamBe (
   input  logic                           clk,
   input  sharedMemPkg::memReqT           reqA,
   input  sharedMemPkg::memReqT           reqB,
   output logic [sharedMemPkg::DataW-1:0] doutA,
   output logic [sharedMemPkg::DataW-1:0] doutB
);

   // Storage array, no reset as with inferred block RAM
   logic [sharedMemPkg::DataW-1:0] mem [2**sharedMemPkg::AddrW];

   // Both ports indexed so one body serves each
   sharedMemPkg::memReqT           portReq [2];
   logic [sharedMemPkg::DataW-1:0] portDout [2];

   assign portReq[0] = reqA;
   assign portReq[1] = reqB;

   for (genvar p = 0; p < 2; p++) begin : gPort
      always @(posedge clk) begin
         if (portReq[p].en) begin
            for (int b = 0; b < sharedMemPkg::ByteCount; b++) begin
               if (portReq[p].be[b]) begin
                  mem[portReq[p].addr][b*8 +: 8] <= portReq[p].wdata[b*8 +: 8];
               end
            end
            portDout[p] <= mem[portReq[p].addr];  // Old word, read-first
         end
      end
   end

   assign doutA = portDout[0];
   assign doutB = portDout[1];

endmodule

/* src/sharedMemPkg.sv */
//=====================================================================
// Shared widths and bus structs for the dual-port APB scratchpad.
// RTL files refer to these by scoped names.
//=====================================================================

package sharedMemPkg;

   localparam int DataW = 32;     // One data word
   localparam int ByteCount = 4;  // Byte lanes per word
   localparam int AddrW = 10;     // 1024 words
   localparam int PAddrW = 16;    // APB byte address

   // Request from an APB master
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [PAddrW-1:0] paddr;     // Bits 1:0 pick the byte lane
      logic [DataW-1:0]  pwdata;
      logic [ByteCount-1:0] pstrb;
   } apbReqT;

   // Response back to the master
   typedef struct packed {
      logic [DataW-1:0] prdata;
      logic             pready;
      logic             pslverr;
   } apbRspT;

   // One RAM port request
   // be of zero with en high is a plain read
   typedef struct packed {
      logic                 en;
      logic [ByteCount-1:0] be;
      logic [AddrW-1:0]     addr;
      logic [DataW-1:0]     wdata;
   } memReqT;

endpackage

/* src/sharedMemTop.sv */
//=====================================================================
// Shared scratchpad top level. Two APB slave ports, the write guard
// and one dual-port RAM; port A is the host side, port B the peripheral.
//=====================================================================
`timescale 1ns/100ps

module sharedMemTop (
   input  logic                 clk,
   input  logic                 arstN,
   input  sharedMemPkg::apbReqT apbA,
   input  sharedMemPkg::apbReqT apbB,
   output sharedMemPkg::apbRspT rspA,
   output sharedMemPkg::apbRspT rspB
);

   sharedMemPkg::memReqT           reqA;
   sharedMemPkg::memReqT           reqB;
   sharedMemPkg::memReqT           ramReqA;
   sharedMemPkg::memReqT           ramReqB;
   logic                           holdA;
   logic                           holdB;
   logic [sharedMemPkg::DataW-1:0] rdA;
   logic [sharedMemPkg::DataW-1:0] rdB;

   assign holdA = 1'b0;  // Port A has priority, never held

   // Host side
   apbMemPort portA (
      .clk   (clk),
      .arstN (arstN),
      .apb   (apbA),
      .rsp   (rspA),
      .hold  (holdA),
      .req   (reqA),
      .rdata (rdA)
   );

   // Peripheral side
   apbMemPort portB (
      .clk   (clk),
      .arstN (arstN),
      .apb   (apbB),
      .rsp   (rspB),
      .hold  (holdB),
      .req   (reqB),
      .rdata (rdB)
   );

   writeConflictGuard guard (
      .reqA    (reqA),
      .reqB    (reqB),
      .ramReqA (ramReqA),
      .ramReqB (ramReqB),
      .holdB   (holdB)
   );

   dpRamBe ram (
      .clk   (clk),
      .reqA  (ramReqA),
      .reqB  (ramReqB),
      .doutA (rdA),
      .doutB (rdB)
   );

endmodule

/* src/writeConflictGuard.sv */
//=====================================================================
// Combinational guard between the two ports and the RAM. Port A wins a
// same-word write collision and port B is held for a later cycle.
//=====================================================================
`timescale 1ns/100ps

module writeConflictGuard (
   input  sharedMemPkg::memReqT reqA,
   input  sharedMemPkg::memReqT reqB,
   output sharedMemPkg::memReqT ramReqA,
   output sharedMemPkg::memReqT ramReqB,
   output logic                 holdB
);

   logic bothWrite;
   logic sameWord;
   logic collide;

   assign bothWrite = reqA.en & reqB.en & (|reqA.be) & (|reqB.be);
   assign sameWord  = (reqA.addr == reqB.addr);
   assign collide   = bothWrite & sameWord;  // Reads never collide, read-first

   assign ramReqA = reqA;

   always_comb begin
      ramReqB    = reqB;
      ramReqB.en = reqB.en & ~collide;  // B retries after A lands
   end

   assign holdB = collide;

endmodule

/* vlog.f */
src/sharedMemPkg.sv
src/dpRamBe.sv
src/apbMemPort.sv
src/writeConflictGuard.sv
src/sharedMemTop.sv
dv/sharedMemTb_sva.sv
dv/sharedMemTb.sv
